/* vlog.f */
+incdir+include
design/cache_pkg.sv
design/cache_decode.sv
design/cache_line_fill.sv
design/cache_data_store.sv
design/cache_result.sv
design/cache_top.sv
test/backend_mem.sv
test/cache_tb.sv

/* Makefile */
SRCS := $(filter %.sv,$(shell cat vlog.f)) include/cache_tb_defs.svh

.PHONY: run clean

run: obj_dir/Vcache_tb
	@out="$$(./obj_dir/Vcache_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

obj_dir/Vcache_tb: vlog.f $(SRCS)
	verilator --binary --timing --top-module cache_tb -o Vcache_tb -f vlog.f

clean:
	rm -rf obj_dir

/* include/cache_tb_defs.svh */
`ifndef CACHE_TB_DEFS_SVH
`define CACHE_TB_DEFS_SVH

localparam logic [31:0] LFSR_SEED = 32'h1c98_b00e;
localparam int NUM_OPS = 400;

// backend latency in cycles, also the ready gap after each beat
localparam int MAX_BE_LAT = 3;

// four beats at worst latency and gap, lookup, replay and response stalls
localparam int OP_CYCLES_MAX = LINE_WORDS * (2 * MAX_BE_LAT + 4) + 24;

localparam int WATCHDOG_CYCLES = NUM_OPS * OP_CYCLES_MAX + 20;  // reset included

`endif

/* test/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;
   import cache_pkg::*;
   `include "cache_tb_defs.svh"

   logic                 clk_i;
   logic                 arst_i;
   logic                 req_valid_i;
   cache_op_e            req_op_i;
   logic [ADDR_W-1:0]    req_addr_i;
   logic                 req_ready_o;
   logic                 resp_valid_o;
   logic [DATA_W-1:0]    resp_data_o;
   logic                 resp_ready_i;
   logic                 be_valid_o;
   logic [BE_ADDR_W-1:0] be_addr_o;
   logic                 be_ready_i;
   logic                 be_rvalid_i;
   logic [DATA_W-1:0]    be_rdata_i;
   logic [1:0]           be_lat;

   logic [31:0]          lfsr;
   logic [TAG_W-1:0]     model_tag [LINES];
   logic [LINES-1:0]     model_valid;
   logic [BE_ADDR_W-1:0] be_reqs [$];
   int                   data_errs;
   int                   timing_errs;
   int                   be_errs;

   cache_top dut0 (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .req_valid_i  (req_valid_i),
      .req_op_i     (req_op_i),
      .req_addr_i   (req_addr_i),
      .req_ready_o  (req_ready_o),
      .resp_valid_o (resp_valid_o),
      .resp_data_o  (resp_data_o),
      .resp_ready_i (resp_ready_i),
      .be_valid_o   (be_valid_o),
      .be_addr_o    (be_addr_o),
      .be_ready_i   (be_ready_i),
      .be_rvalid_i  (be_rvalid_i),
      .be_rdata_i   (be_rdata_i)
   );

   backend_mem u_backend (
      .clk_i    (clk_i),
      .arst_i   (arst_i),
      .lat_i    (be_lat),
      .valid_i  (be_valid_o),
      .addr_i   (be_addr_o),
      .ready_o  (be_ready_i),
      .rvalid_o (be_rvalid_i),
      .rdata_o  (be_rdata_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   function automatic logic [7:0] rand_bits(input int n);
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[6:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
      return v;
   endfunction

   function automatic logic [DATA_W-1:0] expected_word(input logic [BE_ADDR_W-1:0] a);
      return {a ^ 16'hc35a, ~a};
   endfunction

   // word requests seen on the backend, transfer on the following edge
   always @(negedge clk_i) begin
      if (be_valid_o && be_ready_i) begin
         be_reqs.push_back(be_addr_o);
      end
   end

   task automatic check_held(input logic [DATA_W-1:0] held);
      assert (resp_valid_o) else begin
         timing_errs++;
         $display("resp_valid_o dropped while resp_ready_i was low");
      end
      assert (resp_data_o == held) else begin
         data_errs++;
         $display("Fail resp_data_o: got %h, expected %h", resp_data_o, held);
      end
      assert (!req_ready_o) else begin
         timing_errs++;
         $display("Fail req_ready_o: got %h, expected %h", req_ready_o, 1'b0);
      end
   endtask

   task automatic run_op(input cache_op_e op, input logic [ADDR_W-1:0] addr);
      logic [INDEX_W-1:0]   idx;
      logic [TAG_W-1:0]     tag;
      logic                 miss;
      logic                 early;
      logic [DATA_W-1:0]    exp_data;
      logic [DATA_W-1:0]    held;
      logic [BE_ADDR_W-1:0] exp_addr;
      logic [7:0]           r;
      int                   cycles;

      idx      = addr[BYTE_OFF_W+WORD_OFF_W +: INDEX_W];
      tag      = addr[ADDR_W-1 -: TAG_W];
      miss     = (op == op_read) && !(model_valid[idx] && (model_tag[idx] == tag));
      exp_data = (op == op_read) ?
                 expected_word({addr[ADDR_W-1:BYTE_OFF_W], BYTE_OFF_W'(0)}) : '0;
      r        = rand_bits(1);
      early    = r[0];
      r        = rand_bits(2);

      @(posedge clk_i);
      req_valid_i <= 1'b1;
      req_op_i    <= op;
      req_addr_i  <= addr;
      be_lat      <= r[1:0];
      @(negedge clk_i);
      assert (req_ready_o) else begin
         timing_errs++;
         $display("request not accepted, req_ready_o low while idle");
      end
      @(posedge clk_i);  // acceptance edge
      req_valid_i  <= 1'b0;
      resp_ready_i <= early;

      // negedges sampled since acceptance
      cycles = 0;
      do begin
         @(negedge clk_i);
         cycles++;
         assert (!req_ready_o) else begin
            timing_errs++;
            $display("Fail req_ready_o: got %h, expected %h", req_ready_o, 1'b0);
         end
      end while (!resp_valid_o);

      if (miss) begin
         assert (cycles > 3) else begin
            timing_errs++;
            $display("Fail miss latency: got %h, expected more than 3", cycles);
         end
      end else begin
         assert (cycles == 3) else begin  // first negedge after edge N+2
            timing_errs++;
            $display("Fail response latency: got %h, expected %h", cycles, 3);
         end
      end
      assert (resp_data_o == exp_data) else begin
         data_errs++;
         $display("Fail resp_data_o: got %h, expected %h", resp_data_o, exp_data);
      end
      held = resp_data_o;

      if (!early) begin
         r = rand_bits(2);
         repeat (r[1:0]) begin
            @(posedge clk_i);
            @(negedge clk_i);
            check_held(held);
         end
         @(posedge clk_i);
         resp_ready_i <= 1'b1;
         @(negedge clk_i);
         check_held(held);
      end
      @(posedge clk_i);  // response transfers here
      resp_ready_i <= 1'b0;
      @(negedge clk_i);
      assert (!resp_valid_o && req_ready_o) else begin
         timing_errs++;
         $display("response still pending after the handshake");
      end

      assert (be_reqs.size() == (miss ? LINE_WORDS : 0)) else begin
         be_errs++;
         $display("Fail backend requests: got %h, expected %h",
                  be_reqs.size(), miss ? LINE_WORDS : 0);
      end
      for (int i = 0; i < be_reqs.size(); i++) begin
         exp_addr = {addr[ADDR_W-1:BYTE_OFF_W+WORD_OFF_W], WORD_OFF_W'(i), BYTE_OFF_W'(0)};
         assert (be_reqs[i] == exp_addr) else begin
            be_errs++;
            $display("Fail be_addr_o: got %h, expected %h", be_reqs[i], exp_addr);
         end
      end
      be_reqs.delete();

      if (op == op_invalidate) begin
         model_valid[idx] = 1'b0;
      end else begin
         model_valid[idx] = 1'b1;
         model_tag[idx]   = tag;
      end
   endtask

   initial begin
      logic [7:0]       r;
      logic [TAG_W-1:0] tag_pick;
      cache_op_e        op;

      arst_i       <= 1'b1;
      req_valid_i  <= 1'b0;
      req_op_i     <= op_read;
      req_addr_i   <= '0;
      resp_ready_i <= 1'b0;
      be_lat       <= 2'd0;
      lfsr        = LFSR_SEED;
      model_valid = '0;
      data_errs   = 0;
      timing_errs = 0;
      be_errs     = 0;

      repeat (5) @(posedge clk_i);
      arst_i <= 1'b0;
      @(negedge clk_i);
      assert (req_ready_o) else begin
         timing_errs++;
         $display("Fail req_ready_o after reset: got %h, expected %h", req_ready_o, 1'b1);
      end
      assert (!be_valid_o && !resp_valid_o) else begin
         timing_errs++;
         $display("valid outputs high right after reset");
      end

      for (int n = 0; n < NUM_OPS; n++) begin
         r  = rand_bits(2);
         op = (r[1:0] == 2'd0) ? op_invalidate : op_read;
         r  = rand_bits(2);
         tag_pick = (r * 8'h51) ^ 8'h3c;  // four tags share every index
         r  = rand_bits(8);
         run_op(op, {tag_pick, r});
      end

      $display("errors: data %0d, timing %0d, backend %0d", data_errs, timing_errs, be_errs);
      if (data_errs + timing_errs + be_errs == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("watchdog expired before all operations completed");
      $display("Result: FAILED");
      $finish;
   end

endmodule

/* test/backend_mem.sv */
`timescale 1ns/1ps

module backend_mem (
   input  logic                             clk_i,
   input  logic                             arst_i,
   input  logic [1:0]                       lat_i,
   input  logic                             valid_i,
   input  logic [cache_pkg::BE_ADDR_W-1:0]  addr_i,
   output logic                             ready_o,
   output logic                             rvalid_o,
   output logic [cache_pkg::DATA_W-1:0]     rdata_o
);
   import cache_pkg::*;

   logic                 busy;
   logic [1:0]           wait_q;
   logic [1:0]           gap_q;
   logic [BE_ADDR_W-1:0] addr_q;

   // contents are a fixed mix of the byte address
   function automatic logic [DATA_W-1:0] word_at(input logic [BE_ADDR_W-1:0] a);
      return {a ^ 16'hc35a, ~a};
   endfunction

   assign ready_o = !busy && (gap_q == 2'd0);

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         busy     <= 1'b0;
         wait_q   <= 2'd0;
         gap_q    <= 2'd0;
         addr_q   <= '0;
         rvalid_o <= 1'b0;
         rdata_o  <= '0;
      end else begin
         rvalid_o <= 1'b0;
         if (gap_q != 2'd0) begin
            gap_q <= gap_q - 2'd1;
         end
         if (valid_i && ready_o) begin
            busy   <= 1'b1;
            wait_q <= lat_i;
            addr_q <= addr_i;
         end else if (busy) begin
            if (wait_q == 2'd0) begin
               busy     <= 1'b0;
               rvalid_o <= 1'b1;
               rdata_o  <= word_at(addr_q);
               gap_q    <= lat_i;  // ready stays low a while after the beat
            end else begin
               wait_q <= wait_q - 2'd1;
            end
         end
      end
   end

endmodule

/* design/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
   input  logic                             clk_i,
   input  logic                             arst_i,
   input  logic                             req_valid_i,
   input  cache_pkg::cache_op_e             req_op_i,
   input  logic [cache_pkg::ADDR_W-1:0]     req_addr_i,
   output logic                             req_ready_o,
   output logic                             resp_valid_o,
   output logic [cache_pkg::DATA_W-1:0]     resp_data_o,
   input  logic                             resp_ready_i,
   output logic                             be_valid_o,
   output logic [cache_pkg::BE_ADDR_W-1:0]  be_addr_o,
   input  logic                             be_ready_i,
   input  logic                             be_rvalid_i,
   input  logic [cache_pkg::DATA_W-1:0]     be_rdata_i
);
   import cache_pkg::*;

   logic                     fill_start;
   logic [TAG_W+INDEX_W-1:0] fill_tag_idx;
   logic                     fill_done;
   logic                     fill_we;
   logic [WORD_OFF_W-1:0]    fill_word;
   logic [DATA_W-1:0]        fill_data;
   logic                     rd_en;
   logic [INDEX_W-1:0]       rd_index;
   logic [WORD_OFF_W-1:0]    rd_word;
   logic [DATA_W-1:0]        rd_data;
   logic                     lookup_valid;
   cache_op_e                lookup_op;
   logic                     resp_done;

   cache_decode u_decode (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .req_valid_i    (req_valid_i),
      .req_op_i       (req_op_i),
      .req_addr_i     (req_addr_i),
      .req_ready_o    (req_ready_o),
      .fill_start_o   (fill_start),
      .fill_tag_idx_o (fill_tag_idx),
      .fill_done_i    (fill_done),
      .rd_en_o        (rd_en),
      .rd_index_o     (rd_index),
      .rd_word_o      (rd_word),
      .lookup_valid_o (lookup_valid),
      .lookup_op_o    (lookup_op),
      .resp_done_i    (resp_done)
   );

   cache_line_fill u_line_fill (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .fill_start_i   (fill_start),
      .fill_tag_idx_i (fill_tag_idx),
      .fill_done_o    (fill_done),
      .be_valid_o     (be_valid_o),
      .be_addr_o      (be_addr_o),
      .be_ready_i     (be_ready_i),
      .be_rvalid_i    (be_rvalid_i),
      .be_rdata_i     (be_rdata_i),
      .fill_we_o      (fill_we),
      .fill_word_o    (fill_word),
      .fill_data_o    (fill_data)
   );

   // decode holds the missing line's index for the whole refill
   cache_data_store u_data_store (
      .clk_i        (clk_i),
      .fill_we_i    (fill_we),
      .fill_index_i (fill_tag_idx[INDEX_W-1:0]),
      .fill_word_i  (fill_word),
      .fill_data_i  (fill_data),
      .rd_en_i      (rd_en),
      .rd_index_i   (rd_index),
      .rd_word_i    (rd_word),
      .rd_data_o    (rd_data)
   );

   cache_result u_result (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .lookup_valid_i (lookup_valid),
      .lookup_op_i    (lookup_op),
      .rd_data_i      (rd_data),
      .resp_valid_o   (resp_valid_o),
      .resp_data_o    (resp_data_o),
      .resp_ready_i   (resp_ready_i),
      .resp_done_o    (resp_done)
   );

endmodule

/* design/cache_result.sv */
`timescale 1ns/1ps

module cache_result (
   input  logic                          clk_i,
   input  logic                          arst_i,
   input  logic                          lookup_valid_i,
   input  cache_pkg::cache_op_e          lookup_op_i,
   input  logic [cache_pkg::DATA_W-1:0]  rd_data_i,
   output logic                          resp_valid_o,
   output logic [cache_pkg::DATA_W-1:0]  resp_data_o,
   input  logic                          resp_ready_i,
   output logic                          resp_done_o
);
   import cache_pkg::*;

   logic      pend_q;
   cache_op_e op_q;

   assign resp_done_o = resp_valid_o && resp_ready_i;

   always_ff @(posedge clk_i) begin
      if (lookup_valid_i) begin
         op_q <= lookup_op_i;
      end
      // store output is ready now, one cycle after the lookup
      if (pend_q) begin
         resp_data_o <= (op_q == op_invalidate) ? '0 : rd_data_i;
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         pend_q       <= 1'b0;
         resp_valid_o <= 1'b0;
      end else begin
         pend_q <= lookup_valid_i;
         if (pend_q) begin
            resp_valid_o <= 1'b1;
         end else if (resp_done_o) begin
            resp_valid_o <= 1'b0;  // held until the handshake
         end
      end
   end

endmodule

/* design/cache_data_store.sv */
`timescale 1ns/1ps

module cache_data_store (
   input  logic                              clk_i,
   input  logic                              fill_we_i,
   input  logic [cache_pkg::INDEX_W-1:0]     fill_index_i,
   input  logic [cache_pkg::WORD_OFF_W-1:0]  fill_word_i,
   input  logic [cache_pkg::DATA_W-1:0]      fill_data_i,
   input  logic                              rd_en_i,
   input  logic [cache_pkg::INDEX_W-1:0]     rd_index_i,
   input  logic [cache_pkg::WORD_OFF_W-1:0]  rd_word_i,
   output logic [cache_pkg::DATA_W-1:0]      rd_data_o
);
   import cache_pkg::*;

   // one entry per word, line index in the upper address bits
   logic [DATA_W-1:0]             mem [LINES*LINE_WORDS];
   logic [INDEX_W+WORD_OFF_W-1:0] wr_addr;
   logic [INDEX_W+WORD_OFF_W-1:0] rd_addr;

   assign wr_addr = {fill_index_i, fill_word_i};
   assign rd_addr = {rd_index_i, rd_word_i};

   always_ff @(posedge clk_i) begin
      if (fill_we_i) begin
         mem[wr_addr] <= fill_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr];  // valid the cycle after rd_en_i
      end
   end

endmodule

/* design/cache_line_fill.sv */
`timescale 1ns/1ps

module cache_line_fill (
   input  logic                                           clk_i,
   input  logic                                           arst_i,
   input  logic                                           fill_start_i,
   input  logic [cache_pkg::TAG_W+cache_pkg::INDEX_W-1:0] fill_tag_idx_i,
   output logic                                           fill_done_o,
   output logic                                           be_valid_o,
   output logic [cache_pkg::BE_ADDR_W-1:0]                be_addr_o,
   input  logic                                           be_ready_i,
   input  logic                                           be_rvalid_i,
   input  logic [cache_pkg::DATA_W-1:0]                   be_rdata_i,
   output logic                                           fill_we_o,
   output logic [cache_pkg::WORD_OFF_W-1:0]               fill_word_o,
   output logic [cache_pkg::DATA_W-1:0]                   fill_data_o
);
   import cache_pkg::*;

   fill_state_e              state;
   logic [WORD_OFF_W-1:0]    word_cnt;
   logic [TAG_W+INDEX_W-1:0] line_q;
   logic                     req_pend;
   logic                     beat;
   logic                     last_beat;
   logic                     be_accept;

   // one beat per accepted word request, returned in order
   assign beat      = (state == fill_beats) && be_rvalid_i;
   assign last_beat = beat && (word_cnt == WORD_OFF_W'(LINE_WORDS - 1));
   assign be_accept = be_valid_o && be_ready_i;

   // next word is requested only once the previous beat is back
   assign be_valid_o = (state == fill_beats) && !req_pend;
   assign be_addr_o  = {line_q, word_cnt, {BYTE_OFF_W{1'b0}}};

   assign fill_we_o   = beat;
   assign fill_word_o = word_cnt;
   assign fill_data_o = be_rdata_i;
   assign fill_done_o = (state == fill_done);

   always_ff @(posedge clk_i) begin
      if ((state == fill_idle) && fill_start_i) begin
         line_q <= fill_tag_idx_i;
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state    <= fill_idle;
         word_cnt <= '0;
         req_pend <= 1'b0;
      end else begin
         case (state)
            fill_idle: begin
               word_cnt <= '0;
               req_pend <= 1'b0;
               if (fill_start_i) begin
                  state <= fill_beats;
               end
            end
            fill_beats: begin
               if (be_rvalid_i) begin
                  req_pend <= 1'b0;
                  word_cnt <= word_cnt + 1'b1;  // wraps to zero after the last word
               end else if (be_accept) begin
                  req_pend <= 1'b1;
               end
               if (last_beat) begin
                  state <= fill_done;
               end
            end
            fill_done: begin
               // last word lands in the store, decode may replay next cycle
               state <= fill_idle;
            end
            default: state <= fill_idle;
         endcase
      end
   end

endmodule

/* design/cache_decode.sv */
`timescale 1ns/1ps

module cache_decode (
   input  logic                                           clk_i,
   input  logic                                           arst_i,
   input  logic                                           req_valid_i,
   input  cache_pkg::cache_op_e                           req_op_i,
   input  logic [cache_pkg::ADDR_W-1:0]                   req_addr_i,
   output logic                                           req_ready_o,
   output logic                                           fill_start_o,
   output logic [cache_pkg::TAG_W+cache_pkg::INDEX_W-1:0] fill_tag_idx_o,
   input  logic                                           fill_done_i,
   output logic                                           rd_en_o,
   output logic [cache_pkg::INDEX_W-1:0]                  rd_index_o,
   output logic [cache_pkg::WORD_OFF_W-1:0]               rd_word_o,
   output logic                                           lookup_valid_o,
   output cache_pkg::cache_op_e                           lookup_op_o,
   input  logic                                           resp_done_i
);
   import cache_pkg::*;

   typedef enum logic [1:0] {
      dec_idle,
      dec_lookup,
      dec_fill,
      dec_resp
   } dec_state_e;

   dec_state_e         state;
   cache_op_e          op_q;
   logic [ADDR_W-1:0]  addr_q;
   logic [TAG_W-1:0]   tag_mem [LINES];
   logic [LINES-1:0]   valid_q;
   logic [TAG_W-1:0]   tag;
   logic [INDEX_W-1:0] index;
   logic               hit;
   logic               accept;

   assign tag    = addr_q[ADDR_W-1 -: TAG_W];
   assign index  = addr_q[BYTE_OFF_W+WORD_OFF_W +: INDEX_W];
   assign hit    = valid_q[index] && (tag_mem[index] == tag);
   assign accept = req_valid_i && req_ready_o;

   assign req_ready_o    = (state == dec_idle);
   assign fill_start_o   = (state == dec_lookup) && (op_q == op_read) && !hit;
   assign fill_tag_idx_o = {tag, index};
   assign lookup_valid_o = (state == dec_lookup) && ((op_q == op_invalidate) || hit);
   assign lookup_op_o    = op_q;
   assign rd_en_o        = lookup_valid_o;
   assign rd_index_o     = index;
   assign rd_word_o      = addr_q[BYTE_OFF_W +: WORD_OFF_W];

   always_ff @(posedge clk_i) begin
      if (accept) begin
         op_q   <= req_op_i;
         addr_q <= req_addr_i;
      end
      if ((state == dec_fill) && fill_done_i) begin
         tag_mem[index] <= tag;  // line now belongs to this tag
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state   <= dec_idle;
         valid_q <= '0;
      end else begin
         case (state)
            dec_idle: begin
               if (accept) begin
                  state <= dec_lookup;
               end
            end
            dec_lookup: begin
               if (op_q == op_invalidate) begin
                  valid_q[index] <= 1'b0;
                  state          <= dec_resp;
               end else if (hit) begin
                  state <= dec_resp;
               end else begin
                  state <= dec_fill;  // miss, wait for the refill
               end
            end
            dec_fill: begin
               if (fill_done_i) begin
                  valid_q[index] <= 1'b1;
                  state          <= dec_lookup;  // replay, hits this time
               end
            end
            dec_resp: begin
               if (resp_done_i) begin
                  state <= dec_idle;
               end
            end
            default: state <= dec_idle;
         endcase
      end
   end

endmodule

/* design/cache_pkg.sv */
package cache_pkg;

   // front-end and backend sizes
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   // line geometry
   localparam int LINE_WORDS = 4;
   localparam int WORD_OFF_W = 2;
   localparam int LINES = 16;
   localparam int INDEX_W = 4;

   // address fields, tag on top, byte offset at the bottom
   localparam int BYTE_OFF_W = 2;
   localparam int TAG_W = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

   localparam int BE_ADDR_W = ADDR_W;  // backend sees byte addresses too

   typedef enum logic {
      op_read       = 1'b0,
      op_invalidate = 1'b1
   } cache_op_e;

   // refill channel states
   typedef enum logic [1:0] {
      fill_idle  = 2'd0,
      fill_beats = 2'd1,
      fill_done  = 2'd2
   } fill_state_e;

endpackage
